/* logic/core_cfg_pkg.sv */
`default_nettype none

package core_cfg_pkg;

    // data and address width.
    localparam int unsigned xlen = 32;

    // transaction id width on the memory channels.
    localparam int unsigned id_w = 4;

    // first fetch address after reset.
    localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

endpackage

`default_nettype wire

/* logic/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    import core_cfg_pkg::*;

    // read address channel, fetch side to memory.
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] addr;
        logic [id_w-1:0] id;
    } ar_req_t;

    // read data channel, single cycle, no ready.
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] data;
        logic [id_w-1:0] id;
    } r_rsp_t;

    // taken branch or jump from decode.
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] target;
    } redirect_t;

    // instruction handed to decode.
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
    } fetch_out_t;

endpackage

`default_nettype wire

/* logic/pc_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module pc_gen import core_cfg_pkg::*, fetch_pkg::*; #(
    parameter int unsigned     XLEN     = xlen,
    parameter logic [XLEN-1:0] RESET_PC = reset_pc
) (
    input  logic            clk,
    input  logic            rst_n,
    input  redirect_t       redirect,
    input  logic            fetch_done,
    input  logic            pc_hold,
    output logic [XLEN-1:0] curr_pc
);

    logic step_pend;
    logic skip_step;

    // A redirect that lands while a fetch is still owed to decode replaces
    // the step of that fetch, so the next request goes to the target.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            curr_pc   <= RESET_PC;
            step_pend <= 1'b0;
            skip_step <= 1'b0;
        end else if (redirect.valid) begin
            curr_pc   <= redirect.target;
            step_pend <= 1'b0;
            skip_step <= !fetch_done;    // old fetch still in flight.
        end else if (fetch_done && skip_step) begin
            skip_step <= 1'b0;           // step already taken by target.
        end else if (pc_hold) begin
            if (fetch_done) begin
                step_pend <= 1'b1;       // apply once hold drops.
            end
        end else if (fetch_done || step_pend) begin
            curr_pc   <= curr_pc + XLEN'(4);
            step_pend <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* logic/md_hold_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module md_hold_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic md_start,
    input  logic md_done,
    output logic pc_hold
);

    typedef enum logic [1:0] {
        md_idle,
        md_busy,
        md_finish
    } md_state_t;

    md_state_t state;
    md_state_t state_nxt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= md_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            md_idle: begin
                if (md_start) begin
                    state_nxt = md_busy;
                end
            end
            md_busy: begin
                if (md_done) begin
                    state_nxt = md_finish;  // result written back.
                end
            end
            md_finish: begin
                state_nxt = md_start ? md_busy : md_idle;
            end
            default: state_nxt = md_idle;
        endcase
    end

    assign pc_hold = (state == md_busy);

endmodule

`default_nettype wire

/* logic/fetch_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl import core_cfg_pkg::*, fetch_pkg::*; #(
    parameter int unsigned XLEN     = xlen,
    parameter int unsigned ID_W     = id_w,
    parameter int unsigned FETCH_ID = 1
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [XLEN-1:0] curr_pc,
    output ar_req_t         ar_req,
    input  logic            ar_ready,
    input  r_rsp_t          r_rsp,
    output fetch_out_t      fetch_out,
    input  logic            fetch_ready,
    output logic            fetch_done
);

    typedef enum logic [1:0] {
        st_idle,
        st_req,
        st_wait,
        st_deliver
    } state_t;

    localparam logic [ID_W-1:0] fetch_tag = ID_W'(FETCH_ID);

    state_t          state;
    state_t          state_nxt;
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] inst_q;
    logic            req_hs;
    logic            rsp_hit;

    assign req_hs     = ar_req.valid && ar_ready;
    assign rsp_hit    = r_rsp.valid && (r_rsp.id == fetch_tag);  // foreign ids dropped.
    assign fetch_done = (state == st_deliver) && fetch_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: state_nxt = st_req;
            st_req: begin
                if (req_hs) begin
                    state_nxt = st_wait;
                end
            end
            st_wait: begin
                if (rsp_hit) begin
                    state_nxt = st_deliver;
                end
            end
            st_deliver: begin
                if (fetch_ready) begin
                    state_nxt = st_req;
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (req_hs) begin
            pc_q <= curr_pc;             // pc that owns this fetch.
        end
        if ((state == st_wait) && rsp_hit) begin
            inst_q <= r_rsp.data;
        end
    end

    always_comb begin
        ar_req.valid    = (state == st_req);
        ar_req.addr     = curr_pc;
        ar_req.id       = fetch_tag;
        fetch_out.valid = (state == st_deliver);  // held until accepted.
        fetch_out.pc    = pc_q;
        fetch_out.inst  = inst_q;
    end

endmodule

`default_nettype wire

/* logic/inst_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_rom import core_cfg_pkg::*, fetch_pkg::*; #(
    parameter int unsigned     XLEN        = xlen,
    parameter int unsigned     ID_W        = id_w,
    parameter logic [XLEN-1:0] RESET_PC    = reset_pc,
    parameter int unsigned     MEM_LATENCY = 3,
    parameter int unsigned     MEM_WORDS   = 64
) (
    input  logic    clk,
    input  logic    rst_n,
    input  ar_req_t ar_req,
    output logic    ar_ready,
    output r_rsp_t  r_rsp
);

    localparam int unsigned cnt_w  = $clog2(MEM_LATENCY + 1);
    localparam int unsigned addr_w = $clog2(MEM_WORDS);

    logic [XLEN-1:0]  mem [MEM_WORDS];
    logic [XLEN-1:0]  offset;
    logic             in_range;
    logic [XLEN-1:0]  rd_word;
    logic [cnt_w-1:0] cnt;
    logic [XLEN-1:0]  data_q;
    logic [ID_W-1:0]  id_q;

    initial begin
        $readmemh("prog.hex", mem);
    end

    assign offset   = ar_req.addr - RESET_PC;      // below base wraps high.
    assign in_range = (offset >> 2) < XLEN'(MEM_WORDS);
    assign rd_word  = in_range ? mem[offset[addr_w+1:2]] : '0;
    assign ar_ready = (cnt == '0);

    // cnt counts down the latency, response fires on the last count.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (ar_req.valid && ar_ready) begin
            cnt <= cnt_w'(MEM_LATENCY);
        end else if (cnt != '0) begin
            cnt <= cnt - cnt_w'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (ar_req.valid && ar_ready) begin
            data_q <= rd_word;
            id_q   <= ar_req.id;
        end
    end

    always_comb begin
        r_rsp.valid = (cnt == cnt_w'(1));
        r_rsp.data  = data_q;
        r_rsp.id    = id_q;
    end

endmodule

`default_nettype wire

/* logic/fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_top import core_cfg_pkg::*, fetch_pkg::*; #(
    parameter int unsigned     XLEN        = xlen,
    parameter int unsigned     ID_W        = id_w,
    parameter logic [XLEN-1:0] RESET_PC    = reset_pc,
    parameter int unsigned     MEM_LATENCY = 3,
    parameter int unsigned     MEM_WORDS   = 64,
    parameter int unsigned     FETCH_ID    = 1
) (
    input  logic       clk,
    input  logic       rst_n,
    input  redirect_t  redirect,
    input  logic       md_start,
    input  logic       md_done,
    input  logic       fetch_ready,
    output fetch_out_t fetch_out
);

    ar_req_t         ar_req;
    logic            ar_ready;
    r_rsp_t          r_rsp;
    logic [XLEN-1:0] curr_pc;
    logic            fetch_done;
    logic            pc_hold;

    pc_gen #(
        .XLEN     (XLEN),
        .RESET_PC (RESET_PC)
    ) u_pc_gen (
        .clk        (clk),
        .rst_n      (rst_n),
        .redirect   (redirect),
        .fetch_done (fetch_done),
        .pc_hold    (pc_hold),
        .curr_pc    (curr_pc)
    );

    md_hold_ctrl u_md_hold_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .md_start (md_start),
        .md_done  (md_done),
        .pc_hold  (pc_hold)
    );

    fetch_ctrl #(
        .XLEN     (XLEN),
        .ID_W     (ID_W),
        .FETCH_ID (FETCH_ID)
    ) u_fetch_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .curr_pc     (curr_pc),
        .ar_req      (ar_req),
        .ar_ready    (ar_ready),
        .r_rsp       (r_rsp),
        .fetch_out   (fetch_out),
        .fetch_ready (fetch_ready),
        .fetch_done  (fetch_done)
    );

    inst_rom #(
        .XLEN        (XLEN),
        .ID_W        (ID_W),
        .RESET_PC    (RESET_PC),
        .MEM_LATENCY (MEM_LATENCY),
        .MEM_WORDS   (MEM_WORDS)
    ) u_inst_rom (
        .clk      (clk),
        .rst_n    (rst_n),
        .ar_req   (ar_req),
        .ar_ready (ar_ready),
        .r_rsp    (r_rsp)
    );

endmodule

`default_nettype wire

/* tests/fetch_ref.svh */
`ifndef FETCH_REF_SVH
`define FETCH_REF_SVH

// 16-bit Fibonacci LFSR, taps 16 14 13 11.
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
endfunction

// one LFSR step per bit taken.
task automatic draw_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
        val        = (val << 1) | int'(lfsr_state[0]);
        lfsr_state = lfsr_next(lfsr_state);
    end
endtask

// next fetch address after an accepted instruction.
function automatic logic [31:0] ref_next_pc(input logic [31:0] prev, input logic redir_valid,
                                            input logic [31:0] target, input logic held);
    if (redir_valid) begin
        return target;    // branch or jump taken.
    end
    if (held) begin
        return prev;      // step deferred by the multiply/divide.
    end
    return prev + 32'd4;
endfunction

// word that the memory holds at a fetch address.
function automatic logic [31:0] ref_inst(input logic [31:0] pc);
    logic [31:0] offset;
    offset = pc - reset_pc;
    if (offset[1:0] == 2'b00 && (offset >> 2) < depth) begin
        return mem_img[offset >> 2];
    end
    return 32'h0;
endfunction

task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    assert (got === exp) else begin
        errors++;
        $display("mismatch %s %s: expected %h, actual %h", cur_test, what, exp, got);
    end
endtask

task automatic check_flag(input string what, input logic exp, input logic got);
    checks++;
    assert (got === exp) else begin
        errors++;
        $display("mismatch %s %s: expected %b, actual %b", cur_test, what, exp, got);
    end
endtask

`endif

/* tests/fetch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_tb import core_cfg_pkg::*, fetch_pkg::*;;

    localparam int unsigned mem_latency = 3;
    localparam int unsigned depth       = 64;
    localparam int          num_fetch   = 59;
    localparam int          watchdog_ns = num_fetch * (mem_latency + 6) * 8 + 10 * 8 + 4000;

    logic        clk = 1'b0;
    logic        rst_n;
    redirect_t   redirect;
    logic        md_start;
    logic        md_done;
    logic        fetch_ready;
    fetch_out_t  fetch_out;

    logic [31:0] mem_img [depth];
    logic [15:0] lfsr_state;
    string       cur_test = "none";
    int          checks = 0;
    int          errors = 0;
    int          test_checks;
    int          test_errors;
    int          tests_run = 0;
    int          tests_failed = 0;

    // monitor state.
    logic [31:0] exp_pc = reset_pc;
    logic        redir_pend = 1'b0;
    logic [31:0] redir_tgt = '0;
    logic        hold_m = 1'b0;       // pc hold as seen from outside.
    logic        prev_stall = 1'b0;
    fetch_out_t  prev_out = '0;

    `include "fetch_ref.svh"

    always #4 clk = ~clk;

    fetch_top #(
        .RESET_PC    (reset_pc),
        .MEM_LATENCY (mem_latency),
        .MEM_WORDS   (depth),
        .FETCH_ID    (1)
    ) i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .redirect    (redirect),
        .md_start    (md_start),
        .md_done     (md_done),
        .fetch_ready (fetch_ready),
        .fetch_out   (fetch_out)
    );

    // compares every accepted instruction with the reference.
    always @(posedge clk) begin
        if (rst_n) begin
            if (prev_stall) begin
                check_flag("held valid", 1'b1, fetch_out.valid);
                check_word("held pc", prev_out.pc, fetch_out.pc);
                check_word("held inst", prev_out.inst, fetch_out.inst);
            end
            if (redirect.valid) begin
                redir_pend = 1'b1;
                redir_tgt  = redirect.target;
            end
            if (fetch_out.valid && fetch_ready) begin
                check_word("pc", exp_pc, fetch_out.pc);
                check_word("inst", ref_inst(exp_pc), fetch_out.inst);
                exp_pc     = ref_next_pc(exp_pc, redir_pend, redir_tgt, hold_m);
                redir_pend = 1'b0;
            end
            prev_stall = fetch_out.valid && !fetch_ready;
            prev_out   = fetch_out;
            if (hold_m && md_done) begin
                hold_m = 1'b0;
            end else if (!hold_m && md_start) begin
                hold_m = 1'b1;
            end
        end
    end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_checks = checks;
        test_errors = errors;
    endtask

    task automatic end_test();
        int n_chk;
        int n_err;
        n_chk = checks - test_checks;
        n_err = errors - test_errors;
        tests_run++;
        if (n_err != 0) begin
            tests_failed++;
        end
        $display("test %s: %0d checks, %0d errors, %s", cur_test, n_chk, n_err,
                 (n_err == 0) ? "ok" : "FAILED");
    endtask

    task automatic wait_valid();
        while (!fetch_out.valid) begin
            tick();
        end
    endtask

    task automatic idle_gap();
        int gap;
        draw_bits(2, gap);
        repeat (gap) tick();
    endtask

    // accepts n instructions, ready either steady or random.
    task automatic accept_n(input int n, input bit rand_ready);
        int got;
        int r;
        got = 0;
        while (got < n) begin
            if (rand_ready) begin
                draw_bits(2, r);
                fetch_ready = (r != 0);    // low one cycle in four.
            end else begin
                fetch_ready = 1'b1;
            end
            if (fetch_out.valid && fetch_ready) begin
                got++;
            end
            tick();
        end
        fetch_ready = 1'b0;
    endtask

    initial begin
        rst_n       = 1'b0;
        redirect    = '0;
        md_start    = 1'b0;
        md_done     = 1'b0;
        fetch_ready = 1'b0;
        lfsr_state  = 16'd20213;
        $readmemh("prog.hex", mem_img);

        begin_test("reset");
        repeat (10) begin
            tick();
            check_flag("valid in reset", 1'b0, fetch_out.valid);
        end
        rst_n = 1'b1;
        tick();
        check_flag("valid after reset", 1'b0, fetch_out.valid);
        accept_n(1, 1'b0);
        end_test();

        begin_test("sequential");
        accept_n(30, 1'b0);
        end_test();

        begin_test("backpressure");
        accept_n(20, 1'b1);
        end_test();

        begin_test("redirect");
        wait_valid();
        idle_gap();
        redirect.valid  = 1'b1;
        redirect.target = reset_pc + 32'd40;    // word ten.
        tick();
        redirect = '0;
        accept_n(4, 1'b0);
        end_test();

        begin_test("md_hold");
        wait_valid();
        idle_gap();
        md_start = 1'b1;
        tick();
        md_start    = 1'b0;
        fetch_ready = 1'b1;    // accepted while held.
        tick();
        fetch_ready = 1'b0;
        wait_valid();
        md_done = 1'b1;
        tick();
        md_done = 1'b0;
        accept_n(3, 1'b0);
        end_test();

        $display("tests: %0d run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("timeout: the fetch stream stopped before all tests finished");
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

/* prog.hex */
// one 32-bit instruction word per line, word 0 at the reset address
00100093
00200113
00300193
00400213
00500293
00600313
00700393
00800413
00900093
00a00113
00b00193
00c00213
00d00293
00e00313
00f00393
01000413
01100093
01200113
01300193
01400213
01500293
01600313
01700393
01800413
01900093
01a00113
01b00193
01c00213
01d00293
01e00313
01f00393
02000413
02100093
02200113
02300193
02400213
02500293
02600313
02700393
02800413
02900093
02a00113
02b00193
02c00213
02d00293
02e00313
02f00393
03000413
03100093
03200113
03300193
03400213
03500293
03600313
03700393
03800413
03900093
03a00113
03b00193
03c00213
03d00293
03e00313
03f00393
04000413

/* list.f */
logic/core_cfg_pkg.sv
logic/fetch_pkg.sv
logic/pc_gen.sv
logic/md_hold_ctrl.sv
logic/fetch_ctrl.sv
logic/inst_rom.sv
logic/fetch_top.sv
+incdir+tests
tests/fetch_tb.sv

/* Makefile */
TOP = fetch_tb

.PHONY: all lint clean

all:
	verilator --binary --timing -Wno-fatal -f list.f --top-module $(TOP) -o sim
	out=$$(./obj_dir/sim); echo "$$out"; echo "$$out" | grep -q "^Verification passed$$"

lint:
	verilator --lint-only --timing -Wall -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir
